//--- compile.f
design/riscv_pkg.sv
design/alu.sv
design/imm_extend.sv
design/register_file.sv
design/control_unit.sv
design/datapath.sv
design/riscv_core.sv
verification/riscv_core_assertions.sv
verification/riscv_core_tb.sv

//--- design/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu import riscv_pkg::*; (
    input  word_t      a,
    input  word_t      b,
    input  alu_op_e    op,
    output word_t      y,
    output alu_flags_t flags
);
    logic        is_sub;
    logic        is_arith;
    word_t       b_eff;
    logic [32:0] sum;
    logic        carry;
    logic        overflow;

    // One adder serves add and sub, sub as a + ~b + 1.
    assign is_sub   = (op == ALU_SUB);
    assign is_arith = (op == ALU_ADD) || is_sub;
    assign b_eff    = is_sub ? ~b : b;
    assign sum      = {1'b0, a} + {1'b0, b_eff} + {32'd0, is_sub};

    always_comb begin
        case (op)
            ALU_ADD:    y = sum[31:0];
            ALU_SUB:    y = sum[31:0];
            ALU_AND:    y = a & b;
            ALU_OR:     y = a | b;
            ALU_XOR:    y = a ^ b;
            ALU_SLT:    y = {31'd0, $signed(a) < $signed(b)};
            ALU_SLTU:   y = {31'd0, a < b};
            // Shift amount is the low five bits of b.
            ALU_SLL:    y = a << b[4:0];
            ALU_SRL:    y = a >> b[4:0];
            ALU_SRA:    y = word_t'($signed(a) >>> b[4:0]);
            ALU_PASS_B: y = b;
            default:    y = '0;
        endcase
    end

    // Carry out is the no-borrow bit on a subtract.
    assign carry = is_arith ? sum[32] : 1'b0;
    // Signed overflow, operands alike in sign but result differs.
    assign overflow = is_arith ? ((a[31] == b_eff[31]) && (sum[31] != a[31])) : 1'b0;

    assign flags = {y == '0, y[31], carry, overflow};

endmodule

`default_nettype wire

//--- design/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import riscv_pkg::*; (
    input  logic       reset,
    input  word_t      instr,
    input  alu_flags_t alu_flags,
    output ctrl_t      ctrl,
    output logic       mem_we
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       taken;
    logic       dec_mem_we;
    ctrl_t      dec;

    assign opcode    = instr[6:0];
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    // ALU op from funct3; alt selects sub or sra.
    function automatic alu_op_e decode_alu(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            F3_ADD_SUB: op = alt ? ALU_SUB : ALU_ADD;
            F3_SLL:     op = ALU_SLL;
            F3_SLT:     op = ALU_SLT;
            F3_SLTU:    op = ALU_SLTU;
            F3_XOR:     op = ALU_XOR;
            F3_SR:      op = alt ? ALU_SRA : ALU_SRL;
            F3_OR:      op = ALU_OR;
            default:    op = ALU_AND;
        endcase
        return op;
    endfunction

    // Branch outcome from rs1 - rs2 flags.
    always_comb begin
        case (funct3)
            F3_BEQ:  taken = alu_flags[FLAG_Z];
            F3_BNE:  taken = !alu_flags[FLAG_Z];
            // Signed less than is N xor V.
            F3_BLT:  taken = alu_flags[FLAG_N] ^ alu_flags[FLAG_V];
            F3_BGE:  taken = !(alu_flags[FLAG_N] ^ alu_flags[FLAG_V]);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        // Defaults describe a plain no-write, fall-through step.
        dec.reg_we     = 1'b0;
        dec.imm_src    = IMM_SRC_ITYPE;
        dec.alu_ctrl   = ALU_ADD;
        dec.alu_src_a  = ALU_SRC_REG_1;
        dec.alu_src_b  = ALU_SRC_REG_2;
        dec.result_src = RES_SRC_ALU_OUT;
        dec.pc_src     = PC_SRC_PLUS_4;
        dec_mem_we     = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec.reg_we   = 1'b1;
                dec.alu_ctrl = decode_alu(funct3, funct7_b5);
            end
            OPC_OP_IMM: begin
                dec.reg_we    = 1'b1;
                dec.alu_src_b = ALU_SRC_EXT_IMM;
                // Only srai uses bit 30; addi has no subtract form.
                dec.alu_ctrl  = decode_alu(funct3, (funct3 == F3_SR) && funct7_b5);
                if ((funct3 == F3_SLL) || (funct3 == F3_SR)) begin
                    dec.imm_src = IMM_SRC_ITYPE2;
                end
            end
            OPC_LOAD: begin
                dec.reg_we     = 1'b1;
                dec.alu_src_b  = ALU_SRC_EXT_IMM;
                dec.result_src = RES_SRC_MEM;
            end
            OPC_STORE: begin
                dec.imm_src   = IMM_SRC_STYPE;
                dec.alu_src_b = ALU_SRC_EXT_IMM;
                dec_mem_we    = 1'b1;
            end
            OPC_BRANCH: begin
                dec.imm_src  = IMM_SRC_BTYPE;
                dec.alu_ctrl = ALU_SUB;
                dec.pc_src   = taken ? PC_SRC_PLUS_OFF : PC_SRC_PLUS_4;
            end
            OPC_JAL: begin
                dec.reg_we     = 1'b1;
                dec.imm_src    = IMM_SRC_JTYPE;
                dec.result_src = RES_SRC_PC_PLUS_4;
                dec.pc_src     = PC_SRC_PLUS_OFF;
            end
            OPC_JALR: begin
                dec.reg_we     = 1'b1;
                dec.result_src = RES_SRC_PC_PLUS_4;
                dec.pc_src     = PC_SRC_REG_PLUS_OFF;
            end
            OPC_LUI: begin
                // Immediate goes straight to rd.
                dec.reg_we     = 1'b1;
                dec.imm_src    = IMM_SRC_UTYPE;
                dec.result_src = RES_SRC_EXT_IMM;
            end
            OPC_AUIPC: begin
                dec.reg_we    = 1'b1;
                dec.imm_src   = IMM_SRC_UTYPE;
                dec.alu_src_a = ALU_SRC_PC;
                dec.alu_src_b = ALU_SRC_EXT_IMM;
            end
            default: begin
                dec.reg_we = 1'b0;
            end
        endcase
    end

    // No architectural writes while in reset.
    always_comb begin
        ctrl        = dec;
        ctrl.reg_we = dec.reg_we && !reset;
    end

    assign mem_we = dec_mem_we && !reset;

endmodule

`default_nettype wire

//--- design/datapath.sv
`timescale 1ns/1ps
`default_nettype none

module datapath import riscv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic       clk,
    input  logic       reset,
    input  word_t      instr,
    input  ctrl_t      ctrl,
    input  word_t      read_data,
    output word_t      pc,
    output word_t      alu_out,
    output alu_flags_t alu_flags,
    output word_t      write_data
);
    word_t ext_imm;
    word_t reg_rd1;
    word_t reg_rd2;
    word_t reg_wr_data;
    word_t pc_plus_4;
    word_t pc_plus_off;
    word_t reg_plus_off;
    word_t pc_next;
    word_t alu_op_a;
    word_t alu_op_b;

    imm_extend u_imm_extend (
        .instr   (instr),
        .imm_src (ctrl.imm_src),
        .ext_imm (ext_imm)
    );

    // Fixed rs1, rs2 and rd fields.
    register_file u_register_file (
        .clk   (clk),
        .addr1 (instr[19:15]),
        .addr2 (instr[24:20]),
        .addr3 (instr[11:7]),
        .wd3   (reg_wr_data),
        .we    (ctrl.reg_we),
        .rd1   (reg_rd1),
        .rd2   (reg_rd2)
    );

    // Next PC candidates.
    assign pc_plus_4    = pc + 32'd4;
    assign pc_plus_off  = pc + ext_imm;
    assign reg_plus_off = reg_rd1 + ext_imm;

    always_comb begin
        case (ctrl.pc_src)
            PC_SRC_PLUS_OFF:     pc_next = pc_plus_off;
            // jalr target has bit 0 cleared.
            PC_SRC_REG_PLUS_OFF: pc_next = {reg_plus_off[31:1], 1'b0};
            default:             pc_next = pc_plus_4;
        endcase
    end

    // Only state in the datapath besides the register file.
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    // Operand select.
    always_comb begin
        case (ctrl.alu_src_a)
            ALU_SRC_REG_1:   alu_op_a = reg_rd1;
            ALU_SRC_REG_2:   alu_op_a = reg_rd2;
            ALU_SRC_EXT_IMM: alu_op_a = ext_imm;
            default:         alu_op_a = pc;
        endcase
    end

    always_comb begin
        case (ctrl.alu_src_b)
            ALU_SRC_REG_1:   alu_op_b = reg_rd1;
            ALU_SRC_REG_2:   alu_op_b = reg_rd2;
            ALU_SRC_EXT_IMM: alu_op_b = ext_imm;
            default:         alu_op_b = pc;
        endcase
    end

    alu u_alu (
        .a     (alu_op_a),
        .b     (alu_op_b),
        .op    (ctrl.alu_ctrl),
        .y     (alu_out),
        .flags (alu_flags)
    );

    // Write-back select.
    always_comb begin
        case (ctrl.result_src)
            RES_SRC_PC_PLUS_4: reg_wr_data = pc_plus_4;
            RES_SRC_EXT_IMM:   reg_wr_data = ext_imm;
            RES_SRC_MEM:       reg_wr_data = read_data;
            default:           reg_wr_data = alu_out;
        endcase
    end

    // Store data is always rs2.
    assign write_data = reg_rd2;

endmodule

`default_nettype wire

//--- design/imm_extend.sv
`timescale 1ns/1ps
`default_nettype none

module imm_extend import riscv_pkg::*; (
    input  word_t    instr,
    input  imm_src_e imm_src,
    output word_t    ext_imm
);
    word_t i_imm;
    word_t s_imm;
    word_t b_imm;
    word_t j_imm;
    word_t u_imm;
    word_t sh_imm;

    // Sign bit is always instr[31].
    assign i_imm  = {{20{instr[31]}}, instr[31:20]};
    assign s_imm  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    // Branch and jump offsets are in halfwords, bit 0 is zero.
    assign b_imm  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
    assign u_imm  = {instr[31:12], 12'd0};
    // Shift amount, zero extended.
    assign sh_imm = {27'd0, instr[24:20]};

    always_comb begin
        case (imm_src)
            IMM_SRC_ITYPE:  ext_imm = i_imm;
            IMM_SRC_STYPE:  ext_imm = s_imm;
            IMM_SRC_BTYPE:  ext_imm = b_imm;
            IMM_SRC_JTYPE:  ext_imm = j_imm;
            IMM_SRC_UTYPE:  ext_imm = u_imm;
            IMM_SRC_ITYPE2: ext_imm = sh_imm;
            default:        ext_imm = i_imm;
        endcase
    end

endmodule

`default_nettype wire

//--- design/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file import riscv_pkg::*; (
    input  logic      clk,
    input  reg_addr_t addr1,
    input  reg_addr_t addr2,
    input  reg_addr_t addr3,
    input  word_t     wd3,
    input  logic      we,
    output word_t     rd1,
    output word_t     rd2
);
    word_t regs [32];

    // Write on the edge; x0 is never written.
    always_ff @(posedge clk) begin
        if (we && (addr3 != '0)) begin
            regs[addr3] <= wd3;
        end
    end

    // Combinational reads, x0 reads as zero.
    assign rd1 = (addr1 == '0) ? '0 : regs[addr1];
    assign rd2 = (addr2 == '0) ? '0 : regs[addr2];

endmodule

`default_nettype wire

//--- design/riscv_core.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core import riscv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input  logic  clk,
    input  logic  reset,
    input  word_t instr,
    input  word_t dmem_rdata,
    output word_t imem_addr,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we
);
    // Decoded controls and ALU flags.
    ctrl_t      ctrl;
    alu_flags_t alu_flags;

    control_unit u_control_unit (
        .reset     (reset),
        .instr     (instr),
        .alu_flags (alu_flags),
        .ctrl      (ctrl),
        .mem_we    (dmem_we)
    );

    // PC drives the instruction port, ALU result the data address.
    datapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .ctrl       (ctrl),
        .read_data  (dmem_rdata),
        .pc         (imem_addr),
        .alu_out    (dmem_addr),
        .alu_flags  (alu_flags),
        .write_data (dmem_wdata)
    );

endmodule

`default_nettype wire

//--- design/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

    // Data word or byte address.
    typedef logic [31:0] word_t;
    // Register index, x0 to x31.
    typedef logic [4:0] reg_addr_t;
    // ALU flags, packed as {zero, negative, carry, overflow}.
    typedef logic [3:0] alu_flags_t;

    // Bit positions inside alu_flags_t.
    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_C = 1;
    localparam int FLAG_V = 0;

    // Immediate kinds. ITYPE2 is the unsigned five-bit shift amount.
    typedef enum logic [2:0] {
        IMM_SRC_ITYPE,
        IMM_SRC_STYPE,
        IMM_SRC_BTYPE,
        IMM_SRC_JTYPE,
        IMM_SRC_UTYPE,
        IMM_SRC_ITYPE2
    } imm_src_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    // Operand source, same encoding for both ALU inputs.
    typedef enum logic [1:0] {
        ALU_SRC_REG_1,
        ALU_SRC_REG_2,
        ALU_SRC_EXT_IMM,
        ALU_SRC_PC
    } alu_src_e;

    // Register write-back source.
    typedef enum logic [1:0] {
        RES_SRC_ALU_OUT,
        RES_SRC_PC_PLUS_4,
        RES_SRC_EXT_IMM,
        RES_SRC_MEM
    } res_src_e;

    typedef enum logic [1:0] {
        PC_SRC_PLUS_4,
        PC_SRC_PLUS_OFF,
        PC_SRC_REG_PLUS_OFF
    } pc_src_e;

    // Major opcodes of the supported subset.
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

    // Funct3 of OP and OP_IMM.
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Funct3 of BRANCH.
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    // Datapath controls from the decoder.
    typedef struct packed {
        logic     reg_we;
        imm_src_e imm_src;
        alu_op_e  alu_ctrl;
        alu_src_e alu_src_a;
        alu_src_e alu_src_b;
        res_src_e result_src;
        pc_src_e  pc_src;
    } ctrl_t;

endpackage

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module riscv_core_tb \
    -o riscv_core_sim \
    && ./obj_dir/riscv_core_sim > sim.log 2>&1 \
    && ! grep -q "=== FAIL ===" sim.log \
    && cat sim.log \
    || { cat sim.log 2>/dev/null; echo "simulation failed"; exit 1; }

//--- verification/program_stim.txt
// Program words from address 0, one per line, then the sentinel FFFFFFFF.
// After it, expected stores in order: byte address, stored word.
10000513 // 00 addi x10, x0, 0x100
20000593 // 04 addi x11, x0, 0x200
00500093 // 08 addi x1, x0, 5
FFD00113 // 0c addi x2, x0, -3
002081B3 // 10 add  x3, x1, x2
00352023 // 14 sw   x3, 0(x10)
401101B3 // 18 sub  x3, x2, x1
00352223 // 1c sw   x3, 4(x10)
001121B3 // 20 slt  x3, x2, x1
00352423 // 24 sw   x3, 8(x10)
001131B3 // 28 sltu x3, x2, x1
00352623 // 2c sw   x3, 12(x10)
0020F1B3 // 30 and  x3, x1, x2
00352823 // 34 sw   x3, 16(x10)
0020E1B3 // 38 or   x3, x1, x2
00352A23 // 3c sw   x3, 20(x10)
0020C1B3 // 40 xor  x3, x1, x2
00352C23 // 44 sw   x3, 24(x10)
001091B3 // 48 sll  x3, x1, x1
00352E23 // 4c sw   x3, 28(x10)
001151B3 // 50 srl  x3, x2, x1
02352023 // 54 sw   x3, 32(x10)
401151B3 // 58 sra  x3, x2, x1
02352223 // 5c sw   x3, 36(x10)
0005A023 // 60 sw   x0, 0(x11)   end of test 1
F9C00213 // 64 addi x4, x0, -100
02452423 // 68 sw   x4, 40(x10)
00409213 // 6c slli x4, x1, 4
02452623 // 70 sw   x4, 44(x10)
40115213 // 74 srai x4, x2, 1
02452823 // 78 sw   x4, 48(x10)
12345237 // 7c lui  x4, 0x12345
02452A23 // 80 sw   x4, 52(x10)
00001217 // 84 auipc x4, 0x1
02452C23 // 88 sw   x4, 56(x10)
0005A023 // 8c sw   x0, 0(x11)   end of test 2
00452303 // 90 lw   x6, 4(x10)
02652E23 // 94 sw   x6, 60(x10)
0005A023 // 98 sw   x0, 0(x11)   end of test 3
00108463 // 9c beq  x1, x1, +8   taken
04152023 // a0 sw   x1, 64(x10)  skipped
00208463 // a4 beq  x1, x2, +8   not taken
04152223 // a8 sw   x1, 68(x10)
00209463 // ac bne  x1, x2, +8   taken
04152423 // b0 sw   x1, 72(x10)  skipped
00109463 // b4 bne  x1, x1, +8   not taken
04152623 // b8 sw   x1, 76(x10)
00114463 // bc blt  x2, x1, +8   taken
04152823 // c0 sw   x1, 80(x10)  skipped
0020C463 // c4 blt  x1, x2, +8   not taken
04152A23 // c8 sw   x1, 84(x10)
0020D463 // cc bge  x1, x2, +8   taken
04152C23 // d0 sw   x1, 88(x10)  skipped
00115463 // d4 bge  x2, x1, +8   not taken
04152E23 // d8 sw   x1, 92(x10)
0005A023 // dc sw   x0, 0(x11)   end of test 4
0080046F // e0 jal  x8, +8
06152023 // e4 sw   x1, 96(x10)  skipped
06852223 // e8 sw   x8, 100(x10)
0F800493 // ec addi x9, x0, 0xf8
00448667 // f0 jalr x12, 4(x9)
06152423 // f4 sw   x1, 104(x10) skipped
06152623 // f8 sw   x1, 108(x10) skipped
06C52823 // fc sw   x12, 112(x10)
0005A023 // 100 sw  x0, 0(x11)   end of test 5
03700013 // 104 addi x0, x0, 55
06052A23 // 108 sw  x0, 116(x10)
0005A023 // 10c sw  x0, 0(x11)   end of test 6
0005A223 // 110 sw  x0, 4(x11)   halt
0000006F // 114 jal x0, 0
FFFFFFFF
00000100 00000002
00000104 FFFFFFF8
00000108 00000001
0000010C 00000000
00000110 00000005
00000114 FFFFFFFD
00000118 FFFFFFF8
0000011C 000000A0
00000120 07FFFFFF
00000124 FFFFFFFF
00000200 00000000
00000128 FFFFFF9C
0000012C 00000050
00000130 FFFFFFFE
00000134 12345000
00000138 00001084
00000200 00000000
0000013C FFFFFFF8
00000200 00000000
00000144 00000005
0000014C 00000005
00000154 00000005
0000015C 00000005
00000200 00000000
00000164 000000E4
00000170 000000F4
00000200 00000000
00000174 00000000
00000200 00000000
00000204 00000000

//--- verification/riscv_core_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_assertions import riscv_pkg::*; #(
    parameter word_t RESET_PC = '0
) (
    input logic  clk,
    input logic  reset,
    input word_t imem_addr,
    input logic  dmem_we
);
    // PC only moves in whole words.
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset) imem_addr[1:0] == 2'b00)
        else $error("imem_addr %h is not word aligned", imem_addr);

    // Memory untouched while in reset.
    a_no_store_in_reset: assert property (@(posedge clk) reset |-> !dmem_we)
        else $error("dmem_we high during reset");

    // First fetch comes from the reset vector.
    a_reset_vector: assert property (@(posedge clk) $fell(reset) |-> imem_addr == RESET_PC)
        else $error("first fetch after reset at %h, not the reset vector", imem_addr);

endmodule

bind riscv_core riscv_core_assertions #(
    .RESET_PC (RESET_PC)
) u_core_assertions (
    .clk       (clk),
    .reset     (reset),
    .imem_addr (imem_addr),
    .dmem_we   (dmem_we)
);

`default_nettype wire

//--- verification/riscv_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_core_tb import riscv_pkg::*; ();
    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;
    localparam int STIM_WORDS = 512;
    localparam int MAX_PAIRS  = 128;
    // Ends the program words in the stim file.
    localparam word_t SENTINEL  = 32'hffff_ffff;
    // A store here closes one test.
    localparam word_t TAG_ADDR  = 32'h0000_0200;
    // Last store of the program.
    localparam word_t HALT_ADDR = 32'h0000_0204;

    logic  clk = 1'b0;
    logic  reset = 1'b1;
    word_t instr;
    word_t dmem_rdata;
    word_t imem_addr;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;

    word_t stim_words [STIM_WORDS];
    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t exp_addr [MAX_PAIRS];
    word_t exp_data [MAX_PAIRS];

    int prog_len    = 0;
    int n_pairs     = 0;
    int n_tests     = 0;
    int exp_idx     = 0;
    int test_idx    = 0;
    int test_errors = 0;
    int error_count = 0;
    int pass_count  = 0;
    int fail_count  = 0;
    bit stim_ok     = 1'b0;
    bit started     = 1'b0;
    bit halt_seen   = 1'b0;
    bit timed_out   = 1'b0;

    riscv_core #(
        .RESET_PC (32'h0000_0000)
    ) riscv_core_inst (
        .clk        (clk),
        .reset      (reset),
        .instr      (instr),
        .dmem_rdata (dmem_rdata),
        .imem_addr  (imem_addr),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we)
    );

    // 4 ns period.
    always #2 clk = ~clk;

    // Both memories read combinationally by word address.
    assign instr      = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_addr[9:2]];

    function automatic string test_name(input int idx);
        case (idx)
            0:       return "register ALU";
            1:       return "immediates";
            2:       return "load after store";
            3:       return "branches";
            4:       return "jumps and links";
            5:       return "register x0";
            default: return "extra";
        endcase
    endfunction

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (test_errors == 0) begin
            pass_count++;
            $display("test %0d %s: ok", test_idx + 1, test_name(test_idx));
        end else begin
            fail_count++;
            $display("test %0d %s: %0d mismatches", test_idx + 1, test_name(test_idx),
                     test_errors);
        end
        test_idx++;
        test_errors = 0;
    endtask

    // Compares one store against the next expected pair.
    task automatic record_store(input word_t addr, input word_t data);
        if (exp_idx >= n_pairs) begin
            $display("unexpected store of %h to %h at %0t ns, past the end of the trace",
                     data, addr, $time);
            error_count++;
            test_errors++;
        end else begin
            check_value("dmem_addr", exp_addr[exp_idx], addr);
            check_value("dmem_wdata", exp_data[exp_idx], data);
            exp_idx++;
        end
        if (addr == TAG_ADDR) begin
            finish_test();
        end
        if (addr == HALT_ADDR) begin
            halt_seen = 1'b1;
        end
    endtask

    task automatic load_stimulus();
        int i;
        int p;
        for (i = 0; i < STIM_WORDS; i++) begin
            stim_words[i] = '0;
        end
        // Unused slots hold addi x0, x0, index.
        for (i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = 32'h0000_0013 | (i << 20);
        end
        // Byte address in the low half.
        for (i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] <= 32'hd0d0_0000 | (i << 2);
        end
        $readmemh("verification/program_stim.txt", stim_words);
        i = 0;
        while ((i < STIM_WORDS) && (stim_words[i] != SENTINEL)) begin
            if (i < IMEM_WORDS) begin
                imem[i] = stim_words[i];
            end
            i++;
        end
        prog_len = i;
        // Address and data pairs follow the sentinel.
        p = i + 1;
        while (!stim_ok && (p + 1 < STIM_WORDS) && (n_pairs < MAX_PAIRS)) begin
            exp_addr[n_pairs] = stim_words[p];
            exp_data[n_pairs] = stim_words[p + 1];
            if (stim_words[p] == TAG_ADDR) begin
                n_tests++;
            end
            if (stim_words[p] == HALT_ADDR) begin
                stim_ok = 1'b1;
            end
            n_pairs++;
            p += 2;
        end
        if (!stim_ok) begin
            $display("stimulus file has no halt store in its expected trace");
            error_count++;
        end
    endtask

    // Data memory write and store trace.
    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[dmem_addr[9:2]] <= dmem_wdata;
            record_store(dmem_addr, dmem_wdata);
        end
    end

    // Watchdog sized from the program length.
    initial begin
        wait (started);
        repeat (4 * prog_len + 100) @(posedge clk);
        if (!halt_seen) begin
            $display("watchdog: the halt store never came within %0d cycles",
                     4 * prog_len + 100);
            error_count++;
            timed_out = 1'b1;
        end
    end

    initial begin
        load_stimulus();
        repeat (10) @(posedge clk);
        #1 reset = 1'b0;
        if (stim_ok) begin
            started = 1'b1;
            wait (halt_seen || timed_out);
            repeat (2) @(posedge clk);
            if (exp_idx != n_pairs) begin
                $display("store trace stopped after %0d of %0d expected stores",
                         exp_idx, n_pairs);
                error_count++;
            end
            while (test_idx < n_tests) begin
                $display("test %0d %s: not reached", test_idx + 1, test_name(test_idx));
                fail_count++;
                test_idx++;
            end
        end
        $display("tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count,
                 error_count);
        if ((error_count == 0) && (fail_count == 0) && stim_ok) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
